//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -Wno-fatal --top-module alu_stage_tb -f vlog.f -o alu_stage_sim \
    && ./obj_dir/alu_stage_sim > sim.log 2>&1 \
    || echo "*** TEST FAILED ***" >> sim.log
if grep -qF "*** TEST FAILED ***" sim.log
then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"
exit 0

//--- testbench/alu_stage_tb.sv
`timescale 1ns/1ps

module alu_stage_tb
    import alu_pkg::*;
();

localparam int TIMEOUT_CYCLES = 2000;

logic           clock;
logic           reset;
logic           stall;
logic           flush;
logic           busy;
logic           req_valid;
alu_request_t   req;
pc_t            req_pc;
data_t          cache_bypass;
logic           cache_bypass_valid;
logic           rf_write_en;
reg_addr_t      rf_write_addr;
data_t          rf_write_data;
logic           out_valid;
stage_result_t  out_result;
branch_t        branch;
data_t          alu_bypass;
logic           alu_bypass_valid;

logic [31:0]    lfsr_state = 32'hae08;
int             cycle_count = 0;

alu_stage u_dut (
    .clock              (clock),
    .reset              (reset),
    .stall              (stall),
    .flush              (flush),
    .busy               (busy),
    .req_valid          (req_valid),
    .req                (req),
    .req_pc             (req_pc),
    .cache_bypass       (cache_bypass),
    .cache_bypass_valid (cache_bypass_valid),
    .rf_write_en        (rf_write_en),
    .rf_write_addr      (rf_write_addr),
    .rf_write_data      (rf_write_data),
    .out_valid          (out_valid),
    .out_result         (out_result),
    .branch             (branch),
    .alu_bypass         (alu_bypass),
    .alu_bypass_valid   (alu_bypass_valid)
);

initial
begin
    clock = 1'b0;
end

always #50 clock = ~clock;

always @(posedge clock)
begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        stop_on_failure();
    end
end

////////////////////
// Stimulus helpers
// Taps 32, 22, 2, 1
function automatic logic [31:0] take_bits(input int count);
    logic [31:0] value;
    logic        feedback;
    int          i;
    value = '0;
    for (i = 0; i < count; i++)
    begin
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        value      = {value[30:0], lfsr_state[0]};
    end
    return value;
endfunction

function automatic alu_request_t random_request(input opcode_t op);
    alu_request_t r;
    r.opcode  = op;
    r.ra_addr = reg_addr_t'(take_bits(REG_ADDR_WIDTH));
    r.rb_addr = reg_addr_t'(take_bits(REG_ADDR_WIDTH));
    r.rd_addr = reg_addr_t'(take_bits(REG_ADDR_WIDTH));
    r.ra_data = take_bits(DATA_WIDTH);
    r.rb_data = take_bits(DATA_WIDTH);
    r.offset  = offset_t'(take_bits(OFFSET_WIDTH));
    return r;
endfunction

task automatic next_cycle;
    @(posedge clock);
    #1;
endtask

////////////////////
// Expected values
// a and b are the operands after forwarding
function automatic stage_result_t model_result(
    input alu_request_t r,
    input data_t        a,
    input data_t        b,
    input pc_t          pc
);
    stage_result_t       e;
    logic [DATA_WIDTH:0] sum;
    wide_t               product;
    data_t               offset_value;
    e            = '0;
    e.pc         = pc;
    e.dst_reg    = r.rd_addr;
    offset_value = {16'h0000, r.offset};
    case (r.opcode)
        OP_ADD, OP_ADDI:
        begin
            if (r.opcode == OP_ADD)
                sum = {1'b0, a} + {1'b0, b};
            else
                sum = {1'b0, a} + {1'b0, offset_value};
            e.dcache.data = sum[DATA_WIDTH-1:0];
            // Upper half of the wide sum is just the carry
            e.overflow    = sum[DATA_WIDTH];
            e.reg_write   = 1'b1;
        end
        OP_SUB:
        begin
            e.dcache.data = a - b;
            e.reg_write   = 1'b1;
        end
        OP_MUL:
        begin
            product       = {32'h0000_0000, a} * {32'h0000_0000, b};
            e.dcache.data = product[DATA_WIDTH-1:0];
            e.overflow    = (product[2*DATA_WIDTH-1:DATA_WIDTH] != '0);
            e.reg_write   = 1'b1;
        end
        OP_MOV:
        begin
            e.dcache.data = a;
            e.reg_write   = 1'b1;
        end
        OP_LDB, OP_LDW:
        begin
            sum              = {1'b0, a} + {1'b0, offset_value};
            e.dcache.addr    = sum[DATA_WIDTH-1:0];
            e.dcache.is_byte = (r.opcode == OP_LDB);
            e.overflow       = sum[DATA_WIDTH];
            e.mem_type       = 1'b1;
            e.reg_write      = 1'b1;
        end
        OP_STB, OP_STW:
        begin
            sum               = {1'b0, b} + {1'b0, offset_value};
            e.dcache.addr     = sum[DATA_WIDTH-1:0];
            e.dcache.data     = a;
            e.dcache.is_store = 1'b1;
            e.dcache.is_byte  = (r.opcode == OP_STB);
            e.overflow        = sum[DATA_WIDTH];
            e.mem_type        = 1'b1;
        end
        default:
        begin
            e.reg_write = 1'b0;
        end
    endcase
    return e;
endfunction

function automatic branch_t model_branch(input alu_request_t r, input data_t a, input data_t b);
    branch_t e;
    logic    holds;
    e = '0;
    case (r.opcode)
        OP_BEQ:  holds = (a == b);
        OP_BNE:  holds = (a != b);
        OP_BLT:  holds = (a < b);
        OP_BGT:  holds = (a > b);
        OP_BLE:  holds = (a <= b);
        OP_BGE:  holds = (a >= b);
        OP_JUMP: holds = 1'b1;
        default: holds = 1'b0;
    endcase
    if (holds)
    begin
        e.take   = 1'b1;
        e.target = {16'h0000, r.offset};
    end
    return e;
endfunction

////////////////////
// Compare tasks
task automatic stop_on_failure;
    $display("*** TEST FAILED ***");
    $fatal(1, "Run stopped at the first failure");
endtask

task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected)
    begin
        $display("Error: %s expected 0x%h actual 0x%h", name, expected, actual);
        stop_on_failure();
    end
endtask

task automatic check_result(
    input string         name,
    input stage_result_t expected,
    input stage_result_t actual
);
    if (actual !== expected)
    begin
        $display("Error: %s expected 0x%h actual 0x%h", name, expected, actual);
        stop_on_failure();
    end
endtask

task automatic check_branch(input string name, input branch_t expected, input branch_t actual);
    if (actual !== expected)
    begin
        $display("Error: %s expected 0x%h actual 0x%h", name, expected, actual);
        stop_on_failure();
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
        $display("Error: %s expected 0x%h actual 0x%h", name, expected, actual);
        stop_on_failure();
    end
endtask

// One non-MUL request, result one cycle later
task automatic run_single(input alu_request_t r, input pc_t pc, input data_t a, input data_t b);
    stage_result_t exp_result;
    branch_t       exp_branch;
    exp_result = model_result(r, a, b, pc);
    exp_branch = model_branch(r, a, b);
    req        = r;
    req_pc     = pc;
    req_valid  = 1'b1;
    #1;
    check_bit("alu_bypass_valid", 1'b1, alu_bypass_valid);
    check_data("alu_bypass", exp_result.dcache.data, alu_bypass);
    next_cycle();
    req_valid = 1'b0;
    check_bit("out_valid", 1'b1, out_valid);
    check_result("out_result", exp_result, out_result);
    check_branch("branch", exp_branch, branch);
endtask

////////////////////
// Directed tests
task automatic test_arith;
    opcode_t      ops [4];
    alu_request_t r;
    int           i;
    ops = '{OP_ADD, OP_SUB, OP_ADDI, OP_MOV};
    for (i = 0; i < 16; i++)
    begin
        r = random_request(ops[i % 4]);
        run_single(r, take_bits(PC_WIDTH), r.ra_data, r.rb_data);
    end
    // Nothing presented, so the output drops
    next_cycle();
    check_bit("out_valid", 1'b0, out_valid);
endtask

task automatic test_mul;
    alu_request_t  r;
    stage_result_t expected;
    pc_t           pc;
    int            cycles;
    int            n;
    for (n = 0; n < 2; n++)
    begin
        r  = random_request(OP_MUL);
        pc = take_bits(PC_WIDTH);
        if (n == 0)
        begin
            // Product at least 2^39
            r.ra_data = r.ra_data | 32'h8000_0000;
            r.rb_data = r.rb_data | 32'h0000_0100;
        end
        else
        begin
            r.ra_data = take_bits(12);
            r.rb_data = take_bits(12);
        end
        expected  = model_result(r, r.ra_data, r.rb_data, pc);
        req       = r;
        req_pc    = pc;
        req_valid = 1'b1;
        next_cycle();
        cycles = 1;
        check_bit("busy", 1'b1, busy);
        check_bit("alu_bypass_valid", 1'b0, alu_bypass_valid);
        while (!out_valid && cycles < 4 * MUL_LATENCY)
        begin
            next_cycle();
            cycles++;
        end
        req_valid = 1'b0;
        if (!out_valid)
        begin
            $display("The multiply result never appeared on the output");
            stop_on_failure();
        end
        check_data("mul latency", data_t'(MUL_LATENCY + 1), data_t'(cycles));
        check_result("out_result", expected, out_result);
        check_bit("busy", 1'b0, busy);
    end
endtask

task automatic test_memory;
    opcode_t      ops [4];
    alu_request_t r;
    int           i;
    ops = '{OP_LDB, OP_LDW, OP_STB, OP_STW};
    for (i = 0; i < 12; i++)
    begin
        r = random_request(ops[i % 4]);
        // Last round carries out of the address add
        if (i >= 8)
        begin
            r.ra_data = r.ra_data | 32'hffff_8000;
            r.rb_data = r.rb_data | 32'hffff_8000;
            r.offset  = r.offset | 16'h8000;
        end
        run_single(r, take_bits(PC_WIDTH), r.ra_data, r.rb_data);
    end
endtask

task automatic test_branch;
    opcode_t      ops [7];
    alu_request_t r;
    data_t        small_value;
    data_t        large_value;
    int           i;
    int           k;
    ops = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGT, OP_BLE, OP_BGE, OP_JUMP};
    for (i = 0; i < 7; i++)
    begin
        for (k = 0; k < 3; k++)
        begin
            r           = random_request(ops[i]);
            small_value = take_bits(31);
            // Top bit set about half the time, no wrap
            large_value = small_value + take_bits(31) + 32'd1;
            case (k)
                0:
                begin
                    r.ra_data = small_value;
                    r.rb_data = small_value;
                end
                1:
                begin
                    r.ra_data = small_value;
                    r.rb_data = large_value;
                end
                default:
                begin
                    r.ra_data = large_value;
                    r.rb_data = small_value;
                end
            endcase
            run_single(r, take_bits(PC_WIDTH), r.ra_data, r.rb_data);
        end
    end
endtask

task automatic test_forwarding;
    alu_request_t r;
    data_t        fwd_rf;
    data_t        fwd_cache;
    fwd_rf    = take_bits(DATA_WIDTH);
    fwd_cache = take_bits(DATA_WIDTH);

    // Register 7 becomes the held destination
    r         = random_request(OP_ADD);
    r.ra_addr = 5'd1;
    r.rb_addr = 5'd2;
    r.rd_addr = 5'd7;
    run_single(r, take_bits(PC_WIDTH), r.ra_data, r.rb_data);

    // RF write hits ra, cache forward points elsewhere
    rf_write_en        = 1'b1;
    rf_write_addr      = 5'd3;
    rf_write_data      = fwd_rf;
    cache_bypass       = fwd_cache;
    cache_bypass_valid = 1'b1;
    r         = random_request(OP_MOV);
    r.ra_addr = 5'd3;
    r.rb_addr = 5'd4;
    r.rd_addr = 5'd7;
    run_single(r, take_bits(PC_WIDTH), fwd_rf, r.rb_data);

    // Cache forward of the held destination
    r.ra_addr = 5'd7;
    run_single(r, take_bits(PC_WIDTH), fwd_cache, r.rb_data);

    // Both sources match ra
    rf_write_addr = 5'd7;
    r         = random_request(OP_ADD);
    r.ra_addr = 5'd7;
    r.rb_addr = 5'd4;
    r.rd_addr = 5'd7;
    run_single(r, take_bits(PC_WIDTH), fwd_cache, r.rb_data);

    // Store base register from the RF write
    rf_write_addr = 5'd3;
    r         = random_request(OP_STW);
    r.ra_addr = 5'd5;
    r.rb_addr = 5'd3;
    r.rd_addr = 5'd7;
    run_single(r, take_bits(PC_WIDTH), r.ra_data, fwd_rf);

    // alu_bypass_valid gating, one case per cycle
    req_valid = 1'b1;
    stall     = 1'b1;
    #1;
    check_bit("alu_bypass_valid", 1'b0, alu_bypass_valid);
    next_cycle();
    stall = 1'b0;
    flush = 1'b1;
    #1;
    check_bit("alu_bypass_valid", 1'b0, alu_bypass_valid);
    next_cycle();
    flush     = 1'b0;
    req_valid = 1'b0;
    #1;
    check_bit("alu_bypass_valid", 1'b0, alu_bypass_valid);
    next_cycle();
    rf_write_en        = 1'b0;
    cache_bypass_valid = 1'b0;
endtask

task automatic test_stall_flush;
    alu_request_t  first;
    alu_request_t  second;
    stage_result_t held;
    pc_t           first_pc;
    pc_t           second_pc;
    int            i;
    first    = random_request(OP_ADD);
    first_pc = take_bits(PC_WIDTH);
    run_single(first, first_pc, first.ra_data, first.rb_data);
    held = model_result(first, first.ra_data, first.rb_data, first_pc);

    // Waiting request is held off by the stall
    second    = random_request(OP_SUB);
    second_pc = take_bits(PC_WIDTH);
    req       = second;
    req_pc    = second_pc;
    req_valid = 1'b1;
    stall     = 1'b1;
    for (i = 0; i < 3; i++)
    begin
        next_cycle();
        check_bit("out_valid", 1'b1, out_valid);
        check_result("out_result", held, out_result);
        check_bit("alu_bypass_valid", 1'b0, alu_bypass_valid);
    end
    stall = 1'b0;
    next_cycle();
    req_valid = 1'b0;
    check_bit("out_valid", 1'b1, out_valid);
    check_result("out_result", model_result(second, second.ra_data, second.rb_data, second_pc),
                 out_result);

    // Flush on the edge that would accept a jump
    req       = random_request(OP_JUMP);
    req_pc    = take_bits(PC_WIDTH);
    req_valid = 1'b1;
    flush     = 1'b1;
    next_cycle();
    flush     = 1'b0;
    req_valid = 1'b0;
    check_bit("out_valid", 1'b0, out_valid);
    check_bit("branch.take", 1'b0, branch.take);

    // Flush aborts a multiply, even with stall high
    req       = random_request(OP_MUL);
    req_pc    = take_bits(PC_WIDTH);
    req_valid = 1'b1;
    next_cycle();
    check_bit("busy", 1'b1, busy);
    next_cycle();
    flush = 1'b1;
    stall = 1'b1;
    next_cycle();
    flush = 1'b0;
    stall = 1'b0;
    check_bit("busy", 1'b0, busy);

    // Decode still holds the multiply, so it starts over
    next_cycle();
    check_bit("busy", 1'b1, busy);
    for (i = 0; i < MUL_LATENCY - 1; i++)
    begin
        next_cycle();
    end
    // Flush on the final count keeps the product out
    flush = 1'b1;
    next_cycle();
    flush     = 1'b0;
    req_valid = 1'b0;
    check_bit("out_valid", 1'b0, out_valid);
endtask

////////////////////
// Main sequence
initial
begin
    reset              = 1'b1;
    stall              = 1'b0;
    flush              = 1'b0;
    req_valid          = 1'b0;
    req                = '0;
    req_pc             = '0;
    cache_bypass       = '0;
    cache_bypass_valid = 1'b0;
    rf_write_en        = 1'b0;
    rf_write_addr      = '0;
    rf_write_data      = '0;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    check_bit("out_valid", 1'b0, out_valid);
    check_bit("busy", 1'b0, busy);
    check_bit("branch.take", 1'b0, branch.take);

    test_arith();
    test_mul();
    test_memory();
    test_branch();
    test_forwarding();
    test_stall_flush();

    $display("*** TEST PASSED ***");
    $finish;
end

endmodule

//--- verilog/alu_execute.sv
`timescale 1ns/1ps

module alu_execute
    import alu_pkg::*;
(
    input   alu_request_t   req,
    input   pc_t            req_pc,
    input   logic           req_valid,
    input   operands_t      operands,

    output  stage_result_t  result,
    output  branch_t        branch_next,
    output  data_t          bypass_data
);

wide_t               wide;
logic [DATA_WIDTH:0] addr_sum;
data_t               offset_ext;
logic                cond;

assign offset_ext = data_t'(req.offset);

always_comb
begin
    result           = '0;
    result.pc        = req_pc;
    result.dst_reg   = req.rd_addr;
    branch_next      = '0;
    wide             = '0;
    addr_sum         = '0;
    cond             = 1'b0;

    case (req.opcode)
        ////////////////////
        // Arithmetic
        OP_ADD:
        begin
            wide                 = wide_t'(operands.op_a) + wide_t'(operands.op_b);
            result.dcache.data   = wide[DATA_WIDTH-1:0];
            result.overflow      = |wide[2*DATA_WIDTH-1:DATA_WIDTH];
            result.reg_write     = 1'b1;
        end
        OP_SUB:
        begin
            result.dcache.data   = operands.op_a - operands.op_b;
            result.reg_write     = 1'b1;
        end
        OP_MUL:
        begin
            // Only the low half goes back to the register file
            wide                 = wide_t'(operands.op_a) * wide_t'(operands.op_b);
            result.dcache.data   = wide[DATA_WIDTH-1:0];
            result.overflow      = |wide[2*DATA_WIDTH-1:DATA_WIDTH];
            result.reg_write     = 1'b1;
        end
        OP_ADDI:
        begin
            wide                 = wide_t'(operands.op_a) + wide_t'(offset_ext);
            result.dcache.data   = wide[DATA_WIDTH-1:0];
            result.overflow      = |wide[2*DATA_WIDTH-1:DATA_WIDTH];
            result.reg_write     = 1'b1;
        end
        OP_MOV:
        begin
            result.dcache.data   = operands.op_a;
            result.reg_write     = 1'b1;
        end

        ////////////////////
        // Memory
        OP_LDB, OP_LDW:
        begin
            addr_sum             = {1'b0, operands.op_a} + {1'b0, offset_ext};
            result.dcache.addr   = addr_sum[DATA_WIDTH-1:0];
            result.dcache.is_byte = (req.opcode == OP_LDB);
            result.overflow      = addr_sum[DATA_WIDTH];
            result.mem_type      = 1'b1;
            result.reg_write     = 1'b1;
        end
        OP_STB, OP_STW:
        begin
            // Address from rb, stored value from ra
            addr_sum             = {1'b0, operands.store_data} + {1'b0, offset_ext};
            result.dcache.addr   = addr_sum[DATA_WIDTH-1:0];
            result.dcache.data   = operands.op_a;
            result.dcache.is_store = 1'b1;
            result.dcache.is_byte = (req.opcode == OP_STB);
            result.overflow      = addr_sum[DATA_WIDTH];
            result.mem_type      = 1'b1;
        end

        ////////////////////
        // Branches, unsigned compare
        OP_BEQ:
        begin
            cond = (operands.op_a == operands.op_b);
        end
        OP_BNE:
        begin
            cond = (operands.op_a != operands.op_b);
        end
        OP_BLT:
        begin
            cond = (operands.op_a < operands.op_b);
        end
        OP_BGT:
        begin
            cond = (operands.op_a > operands.op_b);
        end
        OP_BLE:
        begin
            cond = (operands.op_a <= operands.op_b);
        end
        OP_BGE:
        begin
            cond = (operands.op_a >= operands.op_b);
        end
        OP_JUMP:
        begin
            cond = 1'b1;
        end
        default:
        begin
            cond = 1'b0;
        end
    endcase

    // Target is absolute, taken from the immediate
    if (cond)
    begin
        branch_next.take   = req_valid;
        branch_next.target = pc_t'(req.offset);
    end
end

// Value forwarded to decode before it is registered
assign bypass_data = result.dcache.data;

endmodule

//--- verilog/alu_pkg.sv
package alu_pkg;

    ////////////////////
    // Widths
    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int PC_WIDTH       = 32;
    localparam int OFFSET_WIDTH   = 16;
    localparam int OPCODE_WIDTH   = 7;

    // Multiply occupies the stage for this many non-stalled cycles
    localparam int MUL_LATENCY     = 4;
    localparam int MUL_COUNT_WIDTH = $clog2(MUL_LATENCY);

    ////////////////////
    // Plain vector types
    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [2*DATA_WIDTH-1:0]   wide_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [PC_WIDTH-1:0]       pc_t;
    typedef logic [OFFSET_WIDTH-1:0]   offset_t;
    typedef logic [OPCODE_WIDTH-1:0]   opcode_t;

    ////////////////////
    // Opcodes
    // R-type arithmetic
    localparam opcode_t OP_ADD  = 7'h00;
    localparam opcode_t OP_SUB  = 7'h01;
    localparam opcode_t OP_MUL  = 7'h02;
    localparam opcode_t OP_ADDI = 7'h03;
    localparam opcode_t OP_MOV  = 7'h04;

    // Memory
    localparam opcode_t OP_LDB  = 7'h10;
    localparam opcode_t OP_LDW  = 7'h11;
    localparam opcode_t OP_STB  = 7'h12;
    localparam opcode_t OP_STW  = 7'h13;

    // Control flow
    localparam opcode_t OP_BEQ  = 7'h30;
    localparam opcode_t OP_JUMP = 7'h31;
    localparam opcode_t OP_BNE  = 7'h32;
    localparam opcode_t OP_BLT  = 7'h33;
    localparam opcode_t OP_BGT  = 7'h34;
    localparam opcode_t OP_BLE  = 7'h35;
    localparam opcode_t OP_BGE  = 7'h36;

    ////////////////////
    // Bundles
    // Decoded instruction from decode stage
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t ra_addr;
        reg_addr_t rb_addr;
        reg_addr_t rd_addr;
        data_t     ra_data;
        data_t     rb_data;
        offset_t   offset;
    } alu_request_t;

    typedef struct packed {
        data_t addr;
        data_t data;
        logic  is_store;
        logic  is_byte;
    } dcache_request_t;

    // Everything registered towards the data cache stage
    typedef struct packed {
        pc_t             pc;
        reg_addr_t       dst_reg;
        dcache_request_t dcache;
        logic            mem_type;
        logic            reg_write;
        logic            overflow;
    } stage_result_t;

    typedef struct packed {
        logic take;
        pc_t  target;
    } branch_t;

    // Source operands after forwarding
    typedef struct packed {
        data_t op_a;
        data_t op_b;
        data_t store_data;
    } operands_t;

endpackage

//--- verilog/alu_stage.sv
`timescale 1ns/1ps

module alu_stage
    import alu_pkg::*;
(
    input   logic           clock,
    input   logic           reset,

    // Pipeline control
    input   logic           stall,
    input   logic           flush,
    output  logic           busy,

    // Request from decode
    input   logic           req_valid,
    input   alu_request_t   req,
    input   pc_t            req_pc,

    // Forwarding sources
    input   data_t          cache_bypass,
    input   logic           cache_bypass_valid,
    input   logic           rf_write_en,
    input   reg_addr_t      rf_write_addr,
    input   data_t          rf_write_data,

    // To cache stage and fetch
    output  logic           out_valid,
    output  stage_result_t  out_result,
    output  branch_t        branch,

    // Forwarding to decode
    output  data_t          alu_bypass,
    output  logic           alu_bypass_valid
);

operands_t      operands;
stage_result_t  result_next;
branch_t        branch_next;
reg_addr_t      held_dst_reg;
logic           issue_ready;

operand_bypass u_operand_bypass (
    .req                (req),
    .held_dst_reg       (held_dst_reg),
    .cache_bypass       (cache_bypass),
    .cache_bypass_valid (cache_bypass_valid),
    .rf_write_en        (rf_write_en),
    .rf_write_addr      (rf_write_addr),
    .rf_write_data      (rf_write_data),
    .operands           (operands)
);

alu_execute u_alu_execute (
    .req                (req),
    .req_pc             (req_pc),
    .req_valid          (req_valid),
    .operands           (operands),
    .result             (result_next),
    .branch_next        (branch_next),
    .bypass_data        (alu_bypass)
);

mul_sequencer u_mul_sequencer (
    .clock              (clock),
    .reset              (reset),
    .flush              (flush),
    .stall              (stall),
    .req_valid          (req_valid),
    .req_opcode         (req.opcode),
    .busy               (busy),
    .issue_ready        (issue_ready)
);

alu_stage_regs u_alu_stage_regs (
    .clock              (clock),
    .reset              (reset),
    .flush              (flush),
    .stall              (stall),
    .req_valid          (req_valid),
    .issue_ready        (issue_ready),
    .result_next        (result_next),
    .branch_next        (branch_next),
    .out_valid          (out_valid),
    .out_result         (out_result),
    .branch             (branch),
    .held_dst_reg       (held_dst_reg)
);

// Forwarded value only counts when the stage moves this cycle
assign alu_bypass_valid = req_valid && !busy && !stall && !flush;

endmodule

//--- verilog/alu_stage_regs.sv
`timescale 1ns/1ps

module alu_stage_regs
    import alu_pkg::*;
(
    input   logic           clock,
    input   logic           reset,
    input   logic           flush,
    input   logic           stall,
    input   logic           req_valid,
    input   logic           issue_ready,

    input   stage_result_t  result_next,
    input   branch_t        branch_next,

    output  logic           out_valid,
    output  stage_result_t  out_result,
    output  branch_t        branch,
    output  reg_addr_t      held_dst_reg
);

logic           accept;
logic           valid_q;
logic           take_q;
pc_t            target_q;
stage_result_t  result_q;

assign accept = req_valid && issue_ready;

////////////////////
// Control flops
always_ff @(posedge clock)
begin
    if (reset || flush)
    begin
        valid_q <= 1'b0;
        take_q  <= 1'b0;
    end
    else if (!stall)
    begin
        valid_q <= accept;
        take_q  <= accept && branch_next.take;
    end
end

////////////////////
// Payload flops
always_ff @(posedge clock)
begin
    if (!stall && accept)
    begin
        result_q <= result_next;
        target_q <= branch_next.target;
    end
end

assign out_valid     = valid_q;
assign out_result    = result_q;
assign branch.take   = take_q;
assign branch.target = target_q;

// Destination of the instruction now in the cache stage
assign held_dst_reg  = result_q.dst_reg;

endmodule

//--- verilog/mul_sequencer.sv
`timescale 1ns/1ps

module mul_sequencer
    import alu_pkg::*;
(
    input   logic       clock,
    input   logic       reset,
    input   logic       flush,
    input   logic       stall,
    input   logic       req_valid,
    input   opcode_t    req_opcode,

    output  logic       busy,
    output  logic       issue_ready
);

typedef enum logic {
    SEQ_IDLE,
    SEQ_COUNT
} seq_state_t;

seq_state_t                 state;
logic [MUL_COUNT_WIDTH-1:0] count;
logic                       is_mul;
logic                       last_count;

assign is_mul     = (req_opcode == OP_MUL);
assign last_count = (state == SEQ_COUNT) && (count == MUL_COUNT_WIDTH'(MUL_LATENCY - 1));

always_ff @(posedge clock)
begin
    if (reset || flush)
    begin
        state <= SEQ_IDLE;
        count <= '0;
    end
    else if (!stall)
    begin
        case (state)
            SEQ_IDLE:
            begin
                if (req_valid && is_mul)
                begin
                    state <= SEQ_COUNT;
                    count <= '0;
                end
            end
            SEQ_COUNT:
            begin
                // Final count releases the result to the output registers
                if (last_count)
                begin
                    state <= SEQ_IDLE;
                    count <= '0;
                end
                else
                begin
                    count <= count + 1'b1;
                end
            end
            default:
            begin
                state <= SEQ_IDLE;
            end
        endcase
    end
end

assign busy        = (state == SEQ_COUNT);
assign issue_ready = ((state == SEQ_IDLE) && !is_mul) || last_count;

endmodule

//--- verilog/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass
    import alu_pkg::*;
(
    input   alu_request_t   req,
    input   reg_addr_t      held_dst_reg,

    // Forwarding from the cache stage
    input   data_t          cache_bypass,
    input   logic           cache_bypass_valid,

    // Register file write in this cycle
    input   logic           rf_write_en,
    input   reg_addr_t      rf_write_addr,
    input   data_t          rf_write_data,

    output  operands_t      operands
);

// Cache stage first, then the RF write, then the value read at decode
function automatic data_t forward_value(
    input reg_addr_t src_addr,
    input data_t     own_data
);
    data_t value;
    if (cache_bypass_valid && (held_dst_reg == src_addr))
    begin
        value = cache_bypass;
    end
    else if (rf_write_en && (rf_write_addr == src_addr))
    begin
        value = rf_write_data;
    end
    else
    begin
        value = own_data;
    end
    return value;
endfunction

always_comb
begin
    operands.op_a       = forward_value(req.ra_addr, req.ra_data);
    operands.op_b       = forward_value(req.rb_addr, req.rb_data);
    // Base register of a store
    operands.store_data = forward_value(req.rb_addr, req.rb_data);
end

endmodule

//--- vlog.f
verilog/alu_pkg.sv
verilog/operand_bypass.sv
verilog/alu_execute.sv
verilog/mul_sequencer.sv
verilog/alu_stage_regs.sv
verilog/alu_stage.sv
testbench/alu_stage_tb.sv
